//--- Bender.yml
package:
  name: ahb_subsys

sources:
  - verilog/ahb_subsys_pkg.sv
  - verilog/ahb_decode_mux.sv
  - verilog/ahb_sram_slave.sv
  - verilog/ahb_reg_slave.sv
  - verilog/ahb_default_slave.sv
  - verilog/ahb_subsys_top.sv
  - target: simulation
    files:
      - sim/ahb_checker.sv
      - sim/tb_ahb_subsys.sv

//--- ahb_subsys.f
verilog/ahb_subsys_pkg.sv
verilog/ahb_decode_mux.sv
verilog/ahb_sram_slave.sv
verilog/ahb_reg_slave.sv
verilog/ahb_default_slave.sv
verilog/ahb_subsys_top.sv
sim/ahb_checker.sv
sim/tb_ahb_subsys.sv

//--- sim/ahb_checker.sv
// Testbench monitor; models SRAM, registers and memory map and checks every data phase

`default_nettype none

module ahb_checker import ahb_subsys_pkg::*;
(
   input  wire            HCLK,
   input  wire            HRESETn,
   input  wire ahb_req_t  req,
   input  wire ahb_data_t hwdata,
   input  wire ahb_rsp_t  rsp,
   output int             err_count,
   output int             check_count
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int SRAM_WORDS = 2**(SRAM_ADDR_BITS-2);

   // Reference contents of the two backed regions
   ahb_data_t  sram_model [SRAM_WORDS];
   ahb_data_t  regs_model [REG_COUNT];

   // Response as it will be seen on the coming rising edge
   ahb_rsp_t   rsp_s;

   // Transfer that owns the current data phase
   logic       dp_active;
   ahb_req_t   dp_req;
   int         low_cnt;
   logic       prev_hresp;

   // ----------------------------------------------------------------------
   // Memory map rules
   // ----------------------------------------------------------------------

   function automatic int region_of(input ahb_addr_t addr);
      int region;
      region = SLV_DEFAULT;
      if (addr[31:SRAM_ADDR_BITS] == SRAM_BASE[31:SRAM_ADDR_BITS])
         region = SLV_SRAM;
      else if (addr[31:REGS_ADDR_BITS] == REGS_BASE[31:REGS_ADDR_BITS])
         region = SLV_REGS;
      return region;
   endfunction

   // Unmapped space and register offsets past the bank
   function automatic logic is_error(input ahb_addr_t addr);
      return (region_of(addr) == SLV_DEFAULT) ||
             ((region_of(addr) == SLV_REGS) && (addr[REGS_ADDR_BITS-1:2] >= REG_COUNT));
   endfunction

   // Cycles with HREADY low before the data phase ends
   function automatic int low_cycles(input ahb_addr_t addr);
      int cycles;
      case (region_of(addr))
         SLV_SRAM: cycles = 0;
         SLV_REGS: cycles = is_error(addr) ? REG_WAIT_STATES + 1 : REG_WAIT_STATES;
         default:  cycles = 1;
      endcase
      return cycles;
   endfunction

   function automatic ahb_data_t read_value(input ahb_addr_t addr);
      ahb_data_t value;
      int        idx;
      if (region_of(addr) == SLV_SRAM)
         value = sram_model[addr[SRAM_ADDR_BITS-1:2]];
      else
      begin
         idx   = int'(addr[REGS_ADDR_BITS-1:2]);
         // Top register is the identity word
         value = (idx == REG_COUNT - 1) ? REG_ID_VALUE : regs_model[idx];
      end
      return value;
   endfunction

   // ----------------------------------------------------------------------
   // Comparison
   // ----------------------------------------------------------------------

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      check_count++;
      if (actual !== expected)
      begin
         err_count++;
         $display("ERR time %0d ns %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   // Closing cycle of a data phase, model updated on good writes
   task automatic finish_phase();
      int idx;
      compare("HRESP", 32'(is_error(dp_req.haddr)), 32'(rsp_s.hresp));
      compare("HREADY wait cycles", low_cycles(dp_req.haddr), low_cnt);
      if (is_error(dp_req.haddr))
         compare("HRESP first error cycle", 32'd1, 32'(prev_hresp));
      else if (!dp_req.hwrite)
         compare("HRDATA", read_value(dp_req.haddr), rsp_s.hrdata);
      else if (region_of(dp_req.haddr) == SLV_SRAM)
         sram_model[dp_req.haddr[SRAM_ADDR_BITS-1:2]] = hwdata;
      else
      begin
         idx = int'(dp_req.haddr[REGS_ADDR_BITS-1:2]);
         if (idx != REG_COUNT - 1)
            regs_model[idx] = hwdata;
      end
   endtask

   initial
   begin
      err_count   = 0;
      check_count = 0;
   end

   // Outputs are registered, so the falling edge value holds until the next rise
   always @(negedge HCLK)
   begin
      rsp_s = rsp;
   end

   always @(posedge HCLK)
   begin
      if (!HRESETn)
      begin
         dp_active  = 1'b0;
         low_cnt    = 0;
         prev_hresp = 1'b0;
         for (int i = 0; i < REG_COUNT; i++)
            regs_model[i] = '0;
      end
      else
      begin
         // IDLE or BUSY data phase, zero-wait OKAY
         if (!dp_active)
         begin
            compare("HREADY", 32'd1, 32'(rsp_s.hreadyout));
            compare("HRESP", 32'd0, 32'(rsp_s.hresp));
         end
         else if (rsp_s.hreadyout)
            finish_phase();
         else
         begin
            low_cnt++;
            if (!is_error(dp_req.haddr))
               compare("HRESP", 32'd0, 32'(rsp_s.hresp));
            prev_hresp = rsp_s.hresp;
         end
         // Address phase taken on this edge
         if (rsp_s.hreadyout)
         begin
            dp_active  = (req.htrans == TRANS_NONSEQ) || (req.htrans == TRANS_SEQ);
            dp_req     = req;
            low_cnt    = 0;
            prev_hresp = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- sim/tb_ahb_subsys.sv
// Testbench top for the AHB-Lite subsystem; plays the bus master and runs directed and random tests

`default_nettype none

module tb_ahb_subsys import ahb_subsys_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT   = 40;
   localparam int RANDOM_XFERS = 600;

   logic       HCLK = 1'b0;
   logic       HRESETn;
   ahb_req_t   req;
   ahb_data_t  hwdata;
   ahb_rsp_t   rsp;
   int         err_count;
   int         check_count;
   integer     seed;

   // Write data owed to the transfer now in its data phase
   ahb_data_t  pend_wdata;
   int         err_base;
   int         chk_base;
   int         test_num;

   ahb_subsys_top DUT (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .req     (req),
      .hwdata  (hwdata),
      .rsp     (rsp)
   );

   ahb_checker u_checker (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .req         (req),
      .hwdata      (hwdata),
      .rsp         (rsp),
      .err_count   (err_count),
      .check_count (check_count)
   );

   // 40 ns clock
   always #20 HCLK = ~HCLK;

   // ----------------------------------------------------------------------
   // Master driver
   // ----------------------------------------------------------------------

   // Address phase plus data of the previous transfer, held until HREADY
   task automatic issue(input ahb_addr_t addr, input logic write, input ahb_data_t wdata,
                        input ahb_trans_e trans);
      int waited;
      @(negedge HCLK);
      req.haddr  = addr;
      req.htrans = trans;
      req.hwrite = write;
      req.hsize  = 3'b010;
      hwdata     = pend_wdata;
      pend_wdata = write ? wdata : '0;
      waited     = 0;
      while (!rsp.hreadyout && (waited < WAIT_LIMIT))
      begin
         @(negedge HCLK);
         waited++;
      end
      if (!rsp.hreadyout)
      begin
         $display("Timeout: HREADY stayed low for %0d cycles at %0d ns", WAIT_LIMIT, $time);
         $display("Simulation finished: FAIL");
         $finish;
      end
   endtask

   task automatic idle_cycles(input int count);
      for (int i = 0; i < count; i++)
         issue('0, 1'b0, '0, TRANS_IDLE);
   endtask

   task automatic write_word(input ahb_addr_t addr);
      issue(addr, 1'b1, $random(seed), TRANS_NONSEQ);
   endtask

   task automatic read_word(input ahb_addr_t addr);
      issue(addr, 1'b0, '0, TRANS_NONSEQ);
   endtask

   // Bad access, then a good read to see the bus recover
   task automatic error_pair(input ahb_addr_t addr);
      write_word(addr);
      read_word(addr);
      read_word(SRAM_BASE);
   endtask

   // One transfer to a random region, mostly back to back
   task automatic random_transfer();
      int        kind;
      ahb_data_t rnd;
      ahb_addr_t addr;
      kind = $unsigned($random(seed)) % 8;
      rnd  = $random(seed);
      case (kind)
         0, 1, 2, 3: addr = SRAM_BASE | {22'd0, rnd[7:0], 2'b00};
         4, 5:       addr = REGS_BASE | {28'd0, rnd[1:0], 2'b00};
         6:          addr = REGS_BASE | {20'd0, rnd[9:0] | 10'd4, 2'b00};
         default:    addr = 32'h2000_0000 | {4'd0, rnd[27:2], 2'b00};
      endcase
      if ((kind == 7) && rnd[31])
         issue(addr, 1'b0, '0, TRANS_IDLE);
      else
         issue(addr, rnd[30], $random(seed), TRANS_NONSEQ);
   endtask

   // ----------------------------------------------------------------------
   // Test sequencing
   // ----------------------------------------------------------------------

   task automatic begin_test();
      err_base = err_count;
      chk_base = check_count;
   endtask

   // Two IDLEs drain the pipeline before the counts are read
   task automatic end_test(input string name);
      idle_cycles(2);
      test_num++;
      $display("Test %0d %s: %0d checks, %0d errors", test_num, name,
               check_count - chk_base, err_count - err_base);
   endtask

   initial
   begin
      seed       = 33772;
      HRESETn    = 1'b0;
      req        = '0;
      hwdata     = '0;
      pend_wdata = '0;
      test_num   = 0;
      repeat (3) @(posedge HCLK);
      @(negedge HCLK);
      HRESETn = 1'b1;

      begin_test();
      idle_cycles(2);
      issue(32'h2000_0000, 1'b0, '0, TRANS_IDLE);
      issue(REGS_BASE, 1'b0, '0, TRANS_IDLE);
      end_test("reset and IDLE");

      begin_test();
      for (int i = 0; i < 256; i++)
         write_word(SRAM_BASE + 32'(i * 4));
      for (int i = 0; i < 64; i++)
         write_word(SRAM_BASE | ((($unsigned($random(seed))) % 256) << 2));
      // Odd stride visits every word once in a new order
      for (int i = 0; i < 256; i++)
         read_word(SRAM_BASE + 32'((((i * 37) + 11) % 256) * 4));
      end_test("SRAM write and read");

      begin_test();
      for (int i = 0; i < REG_COUNT; i++)
         write_word(REGS_BASE + 32'(i * 4));
      for (int i = 0; i < REG_COUNT; i++)
         read_word(REGS_BASE + 32'(i * 4));
      for (int i = REG_COUNT - 1; i >= 0; i--)
      begin
         write_word(REGS_BASE + 32'(i * 4));
         read_word(REGS_BASE + 32'(i * 4));
      end
      end_test("register bank");

      begin_test();
      error_pair(REGS_BASE + 32'h10);
      error_pair(REGS_BASE + 32'hFFC);
      error_pair(32'h0000_0400);
      error_pair(32'h2000_0000);
      error_pair(32'h8000_1230);
      error_pair(32'hFFFF_FFFC);
      end_test("ERROR responses");

      begin_test();
      for (int i = 0; i < RANDOM_XFERS; i++)
         random_transfer();
      end_test("random traffic");

      $display("Total: %0d checks, %0d errors", check_count, err_count);
      if ((err_count == 0) && (check_count > 0))
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/ahb_decode_mux.sv
// Address decoder and response multiplexer; sits between the master port and the three slaves

`default_nettype none

module ahb_decode_mux import ahb_subsys_pkg::*;
(
   input  wire                   HCLK,
   input  wire                   HRESETn,
   input  ahb_addr_t             haddr,
   output logic [SLV_COUNT-1:0]  hsel,
   input  ahb_rsp_t              rsp_default,
   input  ahb_rsp_t              rsp_sram,
   input  ahb_rsp_t              rsp_regs,
   output ahb_rsp_t              rsp
);

   // Region hits on the upper address bits
   logic                  hit_sram;
   logic                  hit_regs;

   // Owner of the current data phase
   logic [SLV_COUNT-1:0]  hsel_q;

   // Responses gathered by select index
   ahb_rsp_t              slv_rsp [SLV_COUNT];

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------

   assign hit_sram = (haddr[31:SRAM_ADDR_BITS] == SRAM_BASE[31:SRAM_ADDR_BITS]);
   assign hit_regs = (haddr[31:REGS_ADDR_BITS] == REGS_BASE[31:REGS_ADDR_BITS]);

   always_comb
   begin
      hsel              = '0;
      hsel[SLV_SRAM]    = hit_sram;
      hsel[SLV_REGS]    = hit_regs;
      // Anything unmapped falls to the default slave
      hsel[SLV_DEFAULT] = ~(hit_sram | hit_regs);
   end

   // ----------------------------------------------------------------------
   // Data phase owner
   // ----------------------------------------------------------------------

   // Address phase ends on an edge with HREADY high
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         hsel_q <= '0;
      end
      else if (rsp.hreadyout)
      begin
         hsel_q <= hsel;
      end
   end

   // ----------------------------------------------------------------------
   // Response mux
   // ----------------------------------------------------------------------

   assign slv_rsp[SLV_DEFAULT] = rsp_default;
   assign slv_rsp[SLV_SRAM]    = rsp_sram;
   assign slv_rsp[SLV_REGS]    = rsp_regs;

   always_comb
   begin
      rsp = '0;
      // OR of the responses masked by the registered selects
      for (int i = 0; i < SLV_COUNT; i++)
      begin
         if (hsel_q[i])
         begin
            rsp.hrdata    = rsp.hrdata | slv_rsp[i].hrdata;
            rsp.hreadyout = rsp.hreadyout | slv_rsp[i].hreadyout;
            rsp.hresp     = rsp.hresp | slv_rsp[i].hresp;
         end
      end
      // Nothing owns the data phase yet, so the bus is ready
      rsp.hreadyout = rsp.hreadyout | ~(|hsel_q);
   end

endmodule

`default_nettype wire

//--- verilog/ahb_default_slave.sv
// Default slave for unmapped addresses; answers active transfers with the two-cycle ERROR

`default_nettype none

module ahb_default_slave import ahb_subsys_pkg::*;
(
   input  wire        HCLK,
   input  wire        HRESETn,
   input  wire        hsel,
   input  wire        hready,
   input  ahb_req_t   req,
   output ahb_rsp_t   rsp
);

   typedef enum logic {
      DEF_OKAY,
      DEF_ERR
   } def_state_e;

   def_state_e  state_q;
   logic        err_tail_q;
   logic        accept;

   // IDLE and BUSY are not accepted and get a zero-wait OKAY
   assign accept = hsel && hready &&
                   ((req.htrans == TRANS_NONSEQ) || (req.htrans == TRANS_SEQ));

   // DEF_ERR is the first ERROR cycle
   // err_tail_q marks the second one, back in DEF_OKAY
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         state_q    <= DEF_OKAY;
         err_tail_q <= 1'b0;
      end
      else
      begin
         err_tail_q <= (state_q == DEF_ERR);
         if (accept)
         begin
            state_q <= DEF_ERR;
         end
         else if (state_q == DEF_ERR)
         begin
            state_q <= DEF_OKAY;
         end
      end
   end

   always_comb
   begin
      rsp.hrdata    = '0;
      rsp.hreadyout = (state_q == DEF_OKAY);
      rsp.hresp     = (state_q == DEF_ERR) || err_tail_q;
   end

endmodule

`default_nettype wire

//--- verilog/ahb_reg_slave.sv
// Four-word register bank with two wait states per transfer and a read-only identity word

`default_nettype none

module ahb_reg_slave import ahb_subsys_pkg::*;
(
   input  wire        HCLK,
   input  wire        HRESETn,
   input  wire        hsel,
   input  wire        hready,
   input  ahb_req_t   req,
   input  ahb_data_t  hwdata,
   output ahb_rsp_t   rsp
);

   typedef enum logic [1:0] {
      REG_IDLE,
      REG_WAIT,
      REG_DONE,
      REG_ERR
   } reg_state_e;

   reg_state_e                     state_q;
   logic [1:0]                     wait_cnt_q;
   logic                           accept;
   logic                           bad_offset;

   // Sampled address phase
   logic [$clog2(REG_COUNT)-1:0]   idx_q;
   logic                           wr_q;
   logic                           err_q;

   // Writable registers, the last index is the identity word
   ahb_data_t                      regs_q [REG_COUNT-1];
   ahb_data_t                      rd_word;

   assign accept = hsel && hready &&
                   ((req.htrans == TRANS_NONSEQ) || (req.htrans == TRANS_SEQ));

   // Word offset past the backed registers
   assign bad_offset = (req.haddr[REGS_ADDR_BITS-1:2] >= REG_COUNT);

   // ----------------------------------------------------------------------
   // Wait state FSM
   // ----------------------------------------------------------------------

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         state_q    <= REG_IDLE;
         wait_cnt_q <= '0;
         idx_q      <= '0;
         wr_q       <= 1'b0;
         err_q      <= 1'b0;
      end
      else
      begin
         case (state_q)
            REG_IDLE, REG_DONE:
            begin
               // A new transfer may be taken on the last data cycle
               if (accept)
               begin
                  state_q    <= REG_WAIT;
                  wait_cnt_q <= 2'(REG_WAIT_STATES - 1);
                  idx_q      <= req.haddr[2 +: $clog2(REG_COUNT)];
                  wr_q       <= req.hwrite;
                  err_q      <= bad_offset;
               end
               else
               begin
                  state_q <= REG_IDLE;
               end
            end
            REG_WAIT:
            begin
               if (wait_cnt_q == '0)
               begin
                  state_q <= err_q ? REG_ERR : REG_DONE;
               end
               else
               begin
                  wait_cnt_q <= wait_cnt_q - 2'd1;
               end
            end
            // First ERROR cycle, the second one is REG_DONE with err_q set
            REG_ERR:
            begin
               state_q <= REG_DONE;
            end
            default:
            begin
               state_q <= REG_IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Register storage
   // ----------------------------------------------------------------------

   // Write completes on the closing edge, identity word ignores it
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         for (int i = 0; i < REG_COUNT - 1; i++)
         begin
            regs_q[i] <= '0;
         end
      end
      else if ((state_q == REG_DONE) && wr_q && !err_q && (idx_q != REG_COUNT - 1))
      begin
         regs_q[idx_q] <= hwdata;
      end
   end

   always_comb
   begin
      rd_word = REG_ID_VALUE;
      if (idx_q != REG_COUNT - 1)
      begin
         rd_word = regs_q[idx_q];
      end
   end

   // Read data only in the last cycle of a good read
   always_comb
   begin
      rsp.hrdata    = ((state_q == REG_DONE) && !wr_q && !err_q) ? rd_word : '0;
      rsp.hreadyout = (state_q == REG_IDLE) || (state_q == REG_DONE);
      rsp.hresp     = (state_q == REG_ERR) || ((state_q == REG_DONE) && err_q);
   end

endmodule

`default_nettype wire

//--- verilog/ahb_sram_slave.sv
// Zero-wait word SRAM behind the decoder; answers every transfer with OKAY in one cycle

`default_nettype none

module ahb_sram_slave import ahb_subsys_pkg::*;
(
   input  wire        HCLK,
   input  wire        HRESETn,
   input  wire        hsel,
   input  wire        hready,
   input  ahb_req_t   req,
   input  ahb_data_t  hwdata,
   output ahb_rsp_t   rsp
);

   // Word storage, 256 entries for the 1 KiB region
   ahb_data_t                    mem [2**(SRAM_ADDR_BITS-2)];

   // Address phase sampled for the data phase
   logic [SRAM_ADDR_BITS-3:0]    idx_q;
   logic                         wr_q;
   logic                         accept;

   // ----------------------------------------------------------------------
   // Address phase
   // ----------------------------------------------------------------------

   // Only NONSEQ and SEQ start a transfer
   assign accept = hsel && hready &&
                   ((req.htrans == TRANS_NONSEQ) || (req.htrans == TRANS_SEQ));

   // Write flag is control, cleared whenever no write is accepted
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         wr_q <= 1'b0;
      end
      else if (hready)
      begin
         wr_q <= accept && req.hwrite;
      end
   end

   // Word index, byte offset bits dropped since every access is a word
   always_ff @(posedge HCLK)
   begin
      if (accept)
      begin
         idx_q <= req.haddr[SRAM_ADDR_BITS-1:2];
      end
   end

   // ----------------------------------------------------------------------
   // Data phase
   // ----------------------------------------------------------------------

   // Single-cycle data phase, so the write lands on its closing edge
   always_ff @(posedge HCLK)
   begin
      if (wr_q)
      begin
         mem[idx_q] <= hwdata;
      end
   end

   // Read straight from the array
   // a read right after a write to the same word sees the new value
   always_comb
   begin
      rsp.hrdata    = mem[idx_q];
      rsp.hreadyout = 1'b1;
      rsp.hresp     = 1'b0;
   end

endmodule

`default_nettype wire

//--- verilog/ahb_subsys_pkg.sv
// Shared bus types, transfer encodings and memory map; imported by every RTL module of the subsystem

`default_nettype none

package ahb_subsys_pkg;

   // ----------------------------------------------------------------------
   // Bus field types
   // ----------------------------------------------------------------------

   typedef logic [31:0] ahb_addr_t;
   typedef logic [31:0] ahb_data_t;
   typedef logic [2:0]  ahb_size_t;

   // HTRANS encoding as on the bus
   typedef enum logic [1:0] {
      TRANS_IDLE   = 2'b00,
      TRANS_BUSY   = 2'b01,
      TRANS_NONSEQ = 2'b10,
      TRANS_SEQ    = 2'b11
   } ahb_trans_e;

   // Address phase signals from the master
   typedef struct packed {
      ahb_addr_t  haddr;
      ahb_trans_e htrans;
      logic       hwrite;
      ahb_size_t  hsize;
   } ahb_req_t;

   // Slave response, hresp high means ERROR
   typedef struct packed {
      ahb_data_t  hrdata;
      logic       hreadyout;
      logic       hresp;
   } ahb_rsp_t;

   // ----------------------------------------------------------------------
   // Memory map
   // ----------------------------------------------------------------------

   // SRAM region, 1 KiB at the bottom of the map
   localparam ahb_addr_t SRAM_BASE      = 32'h0000_0000;
   localparam int        SRAM_ADDR_BITS = 10;

   // Register region, 4 KiB of which only the first words are backed
   localparam ahb_addr_t REGS_BASE       = 32'h4000_0000;
   localparam int        REGS_ADDR_BITS  = 12;
   localparam int        REG_COUNT       = 4;
   localparam ahb_data_t REG_ID_VALUE    = 32'hA4B0_0001;
   localparam int        REG_WAIT_STATES = 2;

   // Select vector bit positions
   localparam int SLV_DEFAULT = 0;
   localparam int SLV_SRAM    = 1;
   localparam int SLV_REGS    = 2;
   localparam int SLV_COUNT   = 3;

endpackage

`default_nettype wire

//--- verilog/ahb_subsys_top.sv
// Subsystem top level; one AHB-Lite master port reaching SRAM, register bank and default slave

`default_nettype none

module ahb_subsys_top import ahb_subsys_pkg::*;
(
   input  wire        HCLK,
   input  wire        HRESETn,
   input  ahb_req_t   req,
   input  ahb_data_t  hwdata,
   output ahb_rsp_t   rsp
);

   logic [SLV_COUNT-1:0]  hsel;
   ahb_rsp_t              rsp_default;
   ahb_rsp_t              rsp_sram;
   ahb_rsp_t              rsp_regs;

   // Bus HREADY fed back to every slave
   logic                  hready;

   assign hready = rsp.hreadyout;

   // ----------------------------------------------------------------------
   // Decoder and slaves
   // ----------------------------------------------------------------------

   ahb_decode_mux u_decode_mux (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .haddr       (req.haddr),
      .hsel        (hsel),
      .rsp_default (rsp_default),
      .rsp_sram    (rsp_sram),
      .rsp_regs    (rsp_regs),
      .rsp         (rsp)
   );

   ahb_sram_slave u_sram (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .hsel    (hsel[SLV_SRAM]),
      .hready  (hready),
      .req     (req),
      .hwdata  (hwdata),
      .rsp     (rsp_sram)
   );

   ahb_reg_slave u_regs (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .hsel    (hsel[SLV_REGS]),
      .hready  (hready),
      .req     (req),
      .hwdata  (hwdata),
      .rsp     (rsp_regs)
   );

   // No write data port, it never stores anything
   ahb_default_slave u_default (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .hsel    (hsel[SLV_DEFAULT]),
      .hready  (hready),
      .req     (req),
      .rsp     (rsp_default)
   );

endmodule

`default_nettype wire
